/* source/dcache_params.svh */
// ==========================================================================
// data cache geometry
// ==========================================================================

`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// byte address and data word
`define DCACHE_ADDR_W   32
`define DCACHE_WORD_W   64
`define DCACHE_STRB_W   8

// address split into tag, index and offset
`define DCACHE_OFFSET_W 3
`define DCACHE_INDEX_W  6
`define DCACHE_SETS     64

// what is left above index and offset
`define DCACHE_TAG_W    (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_OFFSET_W)

`endif

/* source/dcache_pkg.sv */
// ==========================================================================
// data cache vector types
// ==========================================================================

`include "dcache_params.svh"

package dcache_pkg;

    // byte address as seen by the cpu
    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;

    // address bits 31..9
    typedef logic [`DCACHE_TAG_W-1:0] tag_t;

    // address bits 8..3
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;

    // one line holds exactly one word
    typedef logic [`DCACHE_WORD_W-1:0] word_t;

    typedef logic [`DCACHE_STRB_W-1:0] strb_t;

    // two ways
    typedef logic way_t;

endpackage

/* source/dcache_bus_pkg.sv */
// ==========================================================================
// memory side operations
// ==========================================================================

package dcache_bus_pkg;

    // held on mem_op_o until mem_done_i
    typedef enum logic [1:0] {
        MEM_NONE      = 2'd0,
        MEM_WRITEBACK = 2'd1,
        MEM_REFILL    = 2'd2
    } mem_op_e;

endpackage

/* source/dcache_tag_store.sv */
// ==========================================================================
// tag, state and LRU arrays
// ==========================================================================

`include "dcache_params.svh"

module dcache_tag_store (
    input  logic               clk,
    input  logic               rst_n_i,
    input  dcache_pkg::index_t lk_index_i,
    input  dcache_pkg::tag_t   lk_tag_i,
    input  dcache_pkg::way_t   sel_way_i,
    input  logic               fill_i,
    input  dcache_pkg::tag_t   fill_tag_i,
    input  logic               mark_dirty_i,
    input  logic               clean_i,
    input  logic               touch_i,
    input  logic               inval_i,
    output logic               hit_o,
    output dcache_pkg::way_t   hit_way_o,
    output dcache_pkg::way_t   victim_way_o,
    output logic               sel_valid_o,
    output logic               sel_dirty_o,
    output dcache_pkg::tag_t   sel_tag_o
);

    dcache_pkg::tag_t        tag_q   [`DCACHE_SETS][2];
    logic [1:0]              valid_q [`DCACHE_SETS];
    logic [1:0]              dirty_q [`DCACHE_SETS];
    // value is the least recently used way
    logic [`DCACHE_SETS-1:0] lru_q;
    dcache_pkg::index_t      idx_q;
    logic [1:0]              way_hit;

    assign way_hit[0] = valid_q[idx_q][0] && (tag_q[idx_q][0] == lk_tag_i);
    assign way_hit[1] = valid_q[idx_q][1] && (tag_q[idx_q][1] == lk_tag_i);

    assign hit_o     = |way_hit;
    assign hit_way_o = way_hit[1];

    // invalid way first, then LRU
    always_comb begin
        if (!valid_q[idx_q][0]) begin
            victim_way_o = 1'b0;
        end else if (!valid_q[idx_q][1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_q[idx_q];
        end
    end

    assign sel_valid_o = valid_q[idx_q][sel_way_i];
    assign sel_dirty_o = dirty_q[idx_q][sel_way_i];
    assign sel_tag_o   = tag_q[idx_q][sel_way_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            idx_q <= '0;
            lru_q <= '0;
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                valid_q[s]  <= 2'b00;
                dirty_q[s]  <= 2'b00;
                tag_q[s][0] <= '0;
                tag_q[s][1] <= '0;
            end
        end else begin
            idx_q <= lk_index_i;
            if (fill_i) begin
                tag_q[idx_q][sel_way_i]   <= fill_tag_i;
                valid_q[idx_q][sel_way_i] <= 1'b1;
                dirty_q[idx_q][sel_way_i] <= 1'b0;
                lru_q[idx_q]              <= ~sel_way_i;
            end
            if (touch_i) begin
                lru_q[idx_q] <= ~hit_way_o;
            end
            if (mark_dirty_i) begin
                dirty_q[idx_q][hit_way_o] <= 1'b1;
            end
            if (clean_i) begin
                dirty_q[idx_q][sel_way_i] <= 1'b0;
            end
            if (inval_i) begin
                valid_q[idx_q][sel_way_i] <= 1'b0;
                dirty_q[idx_q][sel_way_i] <= 1'b0;
            end
        end
    end

    // a fill never duplicates a tag already present in the set
    a_one_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(way_hit[0] && way_hit[1]))
        else $error("tag hits in both ways");

endmodule

/* source/dcache_data_store.sv */
// ==========================================================================
// two-way data array
// ==========================================================================

`include "dcache_params.svh"

module dcache_data_store (
    input  logic               clk,
    input  dcache_pkg::index_t lk_index_i,
    input  logic               we_i,
    input  dcache_pkg::way_t   wr_way_i,
    input  dcache_pkg::strb_t  wr_strb_i,
    input  dcache_pkg::word_t  wr_data_i,
    output dcache_pkg::word_t  rdata0_o,
    output dcache_pkg::word_t  rdata1_o
);

    dcache_pkg::word_t  mem_q [`DCACHE_SETS][2];
    dcache_pkg::index_t wr_index_q;

    // both ways read every cycle
    always_ff @(posedge clk) begin
        rdata0_o   <= mem_q[lk_index_i][0];
        rdata1_o   <= mem_q[lk_index_i][1];
        wr_index_q <= lk_index_i;
    end

    // byte lanes merge into the stored word
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < `DCACHE_STRB_W; b++) begin
                if (wr_strb_i[b]) begin
                    mem_q[wr_index_q][wr_way_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

endmodule

/* source/dcache_ctrl.sv */
// ==========================================================================
// data cache controller
// ==========================================================================

`include "dcache_params.svh"

module dcache_ctrl (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    cpu_read_i,
    input  logic                    cpu_write_i,
    input  logic                    cpu_fence_i,
    input  dcache_pkg::addr_t       cpu_addr_i,
    input  dcache_pkg::word_t       cpu_wdata_i,
    input  dcache_pkg::strb_t       cpu_strb_i,
    output dcache_pkg::word_t       cpu_rdata_o,
    output logic                    cpu_done_o,
    output dcache_bus_pkg::mem_op_e mem_op_o,
    output dcache_pkg::addr_t       mem_addr_o,
    output dcache_pkg::word_t       mem_wdata_o,
    input  dcache_pkg::word_t       mem_rdata_i,
    input  logic                    mem_done_i,
    output dcache_pkg::index_t      lk_index_o,
    output dcache_pkg::tag_t        lk_tag_o,
    output dcache_pkg::way_t        sel_way_o,
    output logic                    fill_o,
    output dcache_pkg::tag_t        fill_tag_o,
    output logic                    mark_dirty_o,
    output logic                    clean_o,
    output logic                    touch_o,
    output logic                    inval_o,
    input  logic                    hit_i,
    input  dcache_pkg::way_t        hit_way_i,
    input  dcache_pkg::way_t        victim_way_i,
    input  logic                    sel_valid_i,
    input  logic                    sel_dirty_i,
    input  dcache_pkg::tag_t        sel_tag_i,
    output logic                    we_o,
    output dcache_pkg::way_t        wr_way_o,
    output dcache_pkg::strb_t       wr_strb_o,
    output dcache_pkg::word_t       wr_data_o,
    input  dcache_pkg::word_t       rdata0_i,
    input  dcache_pkg::word_t       rdata1_i
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT,
        WRITEBACK,
        REFILL,
        FLUSH_LOOKUP,
        FLUSH_WB
    } ctrl_state_e;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // fence walk position as {set, way}
    logic [`DCACHE_INDEX_W:0] walk_q;
    logic [`DCACHE_INDEX_W:0] walk_d;

    dcache_pkg::way_t   victim_q;
    logic               write_q;

    dcache_pkg::tag_t   req_tag;
    dcache_pkg::index_t req_index;
    dcache_pkg::index_t walk_index;
    dcache_pkg::way_t   sel_way;
    dcache_pkg::word_t  sel_word;
    logic               in_flush;
    logic               flush_mode;
    logic               sel_wb;
    logic               walk_last;
    logic               flush_step;

    assign req_tag    = cpu_addr_i[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign req_index  = cpu_addr_i[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign walk_index = walk_q[`DCACHE_INDEX_W:1];
    assign walk_last  = &walk_q;

    assign in_flush   = (state_q == FLUSH_LOOKUP) || (state_q == FLUSH_WB);
    assign flush_mode = in_flush || ((state_q == IDLE) && cpu_fence_i);

    // during LOOKUP the victim is not latched yet
    always_comb begin
        if (in_flush) begin
            sel_way = walk_q[0];
        end else if (state_q == LOOKUP) begin
            sel_way = victim_way_i;
        end else begin
            sel_way = victim_q;
        end
    end

    assign sel_wb     = sel_valid_i && sel_dirty_i;
    assign sel_word   = sel_way ? rdata1_i : rdata0_i;
    assign flush_step = ((state_q == FLUSH_LOOKUP) && !sel_wb) ||
                        ((state_q == FLUSH_WB) && mem_done_i);

    always_comb begin
        state_d = state_q;
        walk_d  = walk_q;
        case (state_q)
            IDLE: begin
                walk_d = '0;
                if (cpu_fence_i) begin
                    state_d = FLUSH_LOOKUP;
                end else if (cpu_write_i || cpu_read_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_i) begin
                    state_d = HIT;
                end else if (sel_wb) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            HIT: begin
                state_d = IDLE;
            end
            WRITEBACK: begin
                if (mem_done_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                // look up again, which now hits
                if (mem_done_i) begin
                    state_d = LOOKUP;
                end
            end
            FLUSH_LOOKUP, FLUSH_WB: begin
                if (flush_step) begin
                    walk_d  = walk_q + 1'b1;
                    state_d = walk_last ? IDLE : FLUSH_LOOKUP;
                end else if (state_q == FLUSH_LOOKUP) begin
                    state_d = FLUSH_WB;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            walk_q   <= '0;
            victim_q <= 1'b0;
            write_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            walk_q  <= walk_d;
            // write wins over read
            if (state_q == IDLE) begin
                write_q <= cpu_write_i;
            end
            if ((state_q == LOOKUP) && !hit_i) begin
                victim_q <= victim_way_i;
            end
        end
    end

    // stores see the next walk position one cycle ahead
    assign lk_index_o   = flush_mode ? walk_d[`DCACHE_INDEX_W:1] : req_index;
    assign lk_tag_o     = req_tag;
    assign sel_way_o    = sel_way;
    assign fill_o       = (state_q == REFILL) && mem_done_i;
    assign fill_tag_o   = req_tag;
    assign touch_o      = (state_q == HIT);
    assign mark_dirty_o = (state_q == HIT) && write_q;
    assign clean_o      = (state_q == WRITEBACK) && mem_done_i;
    assign inval_o      = flush_step;

    always_comb begin
        we_o      = 1'b0;
        wr_way_o  = hit_way_i;
        wr_strb_o = cpu_strb_i;
        wr_data_o = cpu_wdata_i;
        if (state_q == REFILL) begin
            we_o      = mem_done_i;
            wr_way_o  = victim_q;
            wr_strb_o = '1;
            wr_data_o = mem_rdata_i;
        end else if ((state_q == HIT) && write_q) begin
            we_o = 1'b1;
        end
    end

    always_comb begin
        mem_op_o    = dcache_bus_pkg::MEM_NONE;
        mem_addr_o  = '0;
        mem_wdata_o = '0;
        case (state_q)
            WRITEBACK: begin
                mem_op_o    = dcache_bus_pkg::MEM_WRITEBACK;
                mem_addr_o  = {sel_tag_i, req_index, {`DCACHE_OFFSET_W{1'b0}}};
                mem_wdata_o = sel_word;
            end
            FLUSH_WB: begin
                mem_op_o    = dcache_bus_pkg::MEM_WRITEBACK;
                mem_addr_o  = {sel_tag_i, walk_index, {`DCACHE_OFFSET_W{1'b0}}};
                mem_wdata_o = sel_word;
            end
            REFILL: begin
                mem_op_o   = dcache_bus_pkg::MEM_REFILL;
                mem_addr_o = {req_tag, req_index, {`DCACHE_OFFSET_W{1'b0}}};
            end
            default: begin
                mem_op_o = dcache_bus_pkg::MEM_NONE;
            end
        endcase
    end

    assign cpu_done_o  = (state_q == HIT) || (flush_step && walk_last);
    assign cpu_rdata_o = ((state_q == HIT) && !write_q) ?
                         (hit_way_i ? rdata1_i : rdata0_i) : '0;

    // memory request stays put until it completes
    a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (mem_op_o != dcache_bus_pkg::MEM_NONE) && !mem_done_i |=>
            $stable(mem_op_o) && $stable(mem_addr_o) && $stable(mem_wdata_o))
        else $error("memory request changed before mem_done_i");

    a_done_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        cpu_done_o |-> (cpu_read_i || cpu_write_i || cpu_fence_i))
        else $error("cpu_done_o without a pending request");

endmodule

/* source/dcache_top.sv */
// ==========================================================================
// two-way write-back data cache
// ==========================================================================

module dcache_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    cpu_read_i,
    input  logic                    cpu_write_i,
    input  logic                    cpu_fence_i,
    input  dcache_pkg::addr_t       cpu_addr_i,
    input  dcache_pkg::word_t       cpu_wdata_i,
    input  dcache_pkg::strb_t       cpu_strb_i,
    output dcache_pkg::word_t       cpu_rdata_o,
    output logic                    cpu_done_o,
    output dcache_bus_pkg::mem_op_e mem_op_o,
    output dcache_pkg::addr_t       mem_addr_o,
    output dcache_pkg::word_t       mem_wdata_o,
    input  dcache_pkg::word_t       mem_rdata_i,
    input  logic                    mem_done_i
);

    // lookup and tag update
    dcache_pkg::index_t lk_index;
    dcache_pkg::tag_t   lk_tag;
    dcache_pkg::way_t   sel_way;
    logic               fill;
    dcache_pkg::tag_t   fill_tag;
    logic               mark_dirty;
    logic               clean;
    logic               touch;
    logic               inval;
    logic               hit;
    dcache_pkg::way_t   hit_way;
    dcache_pkg::way_t   victim_way;
    logic               sel_valid;
    logic               sel_dirty;
    dcache_pkg::tag_t   sel_tag;

    // data array port
    logic               we;
    dcache_pkg::way_t   wr_way;
    dcache_pkg::strb_t  wr_strb;
    dcache_pkg::word_t  wr_data;
    dcache_pkg::word_t  rdata0;
    dcache_pkg::word_t  rdata1;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cpu_read_i   (cpu_read_i),
        .cpu_write_i  (cpu_write_i),
        .cpu_fence_i  (cpu_fence_i),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_wdata_i  (cpu_wdata_i),
        .cpu_strb_i   (cpu_strb_i),
        .cpu_rdata_o  (cpu_rdata_o),
        .cpu_done_o   (cpu_done_o),
        .mem_op_o     (mem_op_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_done_i   (mem_done_i),
        .lk_index_o   (lk_index),
        .lk_tag_o     (lk_tag),
        .sel_way_o    (sel_way),
        .fill_o       (fill),
        .fill_tag_o   (fill_tag),
        .mark_dirty_o (mark_dirty),
        .clean_o      (clean),
        .touch_o      (touch),
        .inval_o      (inval),
        .hit_i        (hit),
        .hit_way_i    (hit_way),
        .victim_way_i (victim_way),
        .sel_valid_i  (sel_valid),
        .sel_dirty_i  (sel_dirty),
        .sel_tag_i    (sel_tag),
        .we_o         (we),
        .wr_way_o     (wr_way),
        .wr_strb_o    (wr_strb),
        .wr_data_o    (wr_data),
        .rdata0_i     (rdata0),
        .rdata1_i     (rdata1)
    );

    dcache_tag_store u_tags (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .lk_index_i   (lk_index),
        .lk_tag_i     (lk_tag),
        .sel_way_i    (sel_way),
        .fill_i       (fill),
        .fill_tag_i   (fill_tag),
        .mark_dirty_i (mark_dirty),
        .clean_i      (clean),
        .touch_i      (touch),
        .inval_i      (inval),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .victim_way_o (victim_way),
        .sel_valid_o  (sel_valid),
        .sel_dirty_o  (sel_dirty),
        .sel_tag_o    (sel_tag)
    );

    dcache_data_store u_data (
        .clk        (clk),
        .lk_index_i (lk_index),
        .we_i       (we),
        .wr_way_i   (wr_way),
        .wr_strb_i  (wr_strb),
        .wr_data_i  (wr_data),
        .rdata0_o   (rdata0),
        .rdata1_o   (rdata1)
    );

endmodule

/* tests/tb_dcache_mem.sv */
// ==========================================================================
// backing memory model
// ==========================================================================

module tb_dcache_mem (
    input  logic                    clk,
    input  dcache_bus_pkg::mem_op_e mem_op_i,
    input  dcache_pkg::addr_t       mem_addr_i,
    input  dcache_pkg::word_t       mem_wdata_i,
    output dcache_pkg::word_t       mem_rdata_o,
    output logic                    mem_done_o
);

    // only written-back lines live here
    dcache_pkg::word_t store [dcache_pkg::addr_t];
    int                wb_count;
    int                refill_count;
    dcache_pkg::addr_t last_wb_addr;
    dcache_pkg::word_t last_wb_data;
    logic              busy;
    int                delay;

    function automatic dcache_pkg::word_t initial_word(input dcache_pkg::addr_t line);
        return {line ^ 32'hc3a5_0f1e, line * 32'h9e37_79b9};
    endfunction

    function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t line);
        if (store.exists(line)) begin
            return store[line];
        end
        return initial_word(line);
    endfunction

    // done is a one cycle pulse after 1 to 6 cycles
    initial begin
        mem_done_o   = 1'b0;
        mem_rdata_o  = '0;
        busy         = 1'b0;
        delay        = 0;
        wb_count     = 0;
        refill_count = 0;
        last_wb_addr = '0;
        last_wb_data = '0;
        void'($urandom(32'hb7c1_8de2));
        forever begin
            @(negedge clk);
            if (mem_done_o) begin
                mem_done_o  = 1'b0;
                mem_rdata_o = '0;
                busy        = 1'b0;
            end else if (mem_op_i != dcache_bus_pkg::MEM_NONE) begin
                if (!busy) begin
                    busy  = 1'b1;
                    delay = $urandom_range(6, 1);
                end
                delay = delay - 1;
                if (delay == 0) begin
                    if (mem_op_i == dcache_bus_pkg::MEM_WRITEBACK) begin
                        store[mem_addr_i] = mem_wdata_i;
                        last_wb_addr      = mem_addr_i;
                        last_wb_data      = mem_wdata_i;
                        wb_count          = wb_count + 1;
                    end else begin
                        mem_rdata_o  = read_word(mem_addr_i);
                        refill_count = refill_count + 1;
                    end
                    mem_done_o = 1'b1;
                end
            end
        end
    end

endmodule

/* tests/tb_dcache.sv */
// ==========================================================================
// data cache testbench
// ==========================================================================

module tb_dcache;

    localparam int OP_READ  = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_FENCE = 2;

    // set 2, set 5 and set 8 lines
    localparam dcache_pkg::addr_t ADDR_D = 32'h0000_1010;
    localparam dcache_pkg::addr_t ADDR_A = 32'h0000_0028;
    localparam dcache_pkg::addr_t ADDR_B = 32'h0000_0228;
    localparam dcache_pkg::addr_t ADDR_C = 32'h0000_0428;
    localparam dcache_pkg::addr_t ADDR_E = 32'h0000_2040;
    localparam dcache_pkg::addr_t ADDR_F = 32'h0000_3040;

    logic                    clk;
    logic                    rst_n_i;
    logic                    cpu_read_i;
    logic                    cpu_write_i;
    logic                    cpu_fence_i;
    dcache_pkg::addr_t       cpu_addr_i;
    dcache_pkg::word_t       cpu_wdata_i;
    dcache_pkg::strb_t       cpu_strb_i;
    dcache_pkg::word_t       cpu_rdata_o;
    logic                    cpu_done_o;
    dcache_bus_pkg::mem_op_e mem_op_o;
    dcache_pkg::addr_t       mem_addr_o;
    dcache_pkg::word_t       mem_wdata_o;
    dcache_pkg::word_t       mem_rdata_i;
    logic                    mem_done_i;

    // stimulus table columns
    int                row_op[$];
    dcache_pkg::addr_t row_addr[$];
    dcache_pkg::word_t row_wdata[$];
    dcache_pkg::strb_t row_strb[$];
    bit                row_hit[$];
    int                row_wb[$];
    int                row_refill[$];
    dcache_pkg::addr_t row_wb_addr[$];

    dcache_pkg::word_t ref_mem [dcache_pkg::addr_t];
    dcache_pkg::addr_t written[$];

    dcache_top UUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cpu_read_i  (cpu_read_i),
        .cpu_write_i (cpu_write_i),
        .cpu_fence_i (cpu_fence_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .cpu_strb_i  (cpu_strb_i),
        .cpu_rdata_o (cpu_rdata_o),
        .cpu_done_o  (cpu_done_o),
        .mem_op_o    (mem_op_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_done_i  (mem_done_i)
    );

    tb_dcache_mem u_mem (
        .clk         (clk),
        .mem_op_i    (mem_op_o),
        .mem_addr_i  (mem_addr_o),
        .mem_wdata_i (mem_wdata_o),
        .mem_rdata_o (mem_rdata_i),
        .mem_done_o  (mem_done_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic dcache_pkg::word_t initial_word(input dcache_pkg::addr_t line);
        return {line ^ 32'hc3a5_0f1e, line * 32'h9e37_79b9};
    endfunction

    function automatic dcache_pkg::addr_t line_of(input dcache_pkg::addr_t a);
        return {a[31:3], 3'b000};
    endfunction

    function automatic dcache_pkg::word_t ref_read(input dcache_pkg::addr_t a);
        if (ref_mem.exists(line_of(a))) begin
            return ref_mem[line_of(a)];
        end
        return initial_word(line_of(a));
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_word,
                                                      input dcache_pkg::word_t new_word,
                                                      input dcache_pkg::strb_t strb);
        dcache_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_value(input string name, input dcache_pkg::word_t expected,
                               input dcache_pkg::word_t actual);
        if (expected !== actual) begin
            $display("CHECK FAILED at %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic add_row(input int op, input dcache_pkg::addr_t addr,
                           input dcache_pkg::word_t wdata, input dcache_pkg::strb_t strb,
                           input bit hit, input int wb, input int refill,
                           input dcache_pkg::addr_t wb_addr);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_wdata.push_back(wdata);
        row_strb.push_back(strb);
        row_hit.push_back(hit);
        row_wb.push_back(wb);
        row_refill.push_back(refill);
        row_wb_addr.push_back(wb_addr);
    endtask

    // samples at the rising edge before the DUT updates
    task automatic wait_done(input bit quiet, output int cycles, output dcache_pkg::word_t rdata);
        bit done;
        done   = 1'b0;
        cycles = 0;
        rdata  = '0;
        while (!done && cycles < 200) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (quiet) begin
                check_value("mem_op_o", dcache_pkg::word_t'(dcache_bus_pkg::MEM_NONE),
                            dcache_pkg::word_t'(mem_op_o));
            end
            if (cpu_done_o) begin
                done  = 1'b1;
                rdata = cpu_rdata_o;
            end else begin
                check_value("cpu_rdata_o", 64'd0, cpu_rdata_o);
            end
        end
        if (!done) begin
            $display(">>> FAIL");
            $fatal(1, "cpu_done_o did not arrive within 200 cycles");
        end
    endtask

    task automatic run_row(input int i);
        int                wb_start;
        int                refill_start;
        int                cycles;
        dcache_pkg::word_t rdata;
        wb_start     = u_mem.wb_count;
        refill_start = u_mem.refill_count;
        @(negedge clk);
        cpu_read_i  = (row_op[i] == OP_READ);
        cpu_write_i = (row_op[i] == OP_WRITE);
        cpu_fence_i = (row_op[i] == OP_FENCE);
        cpu_addr_i  = row_addr[i];
        cpu_wdata_i = row_wdata[i];
        cpu_strb_i  = row_strb[i];
        wait_done(row_hit[i], cycles, rdata);
        @(negedge clk);
        cpu_read_i  = 1'b0;
        cpu_write_i = 1'b0;
        cpu_fence_i = 1'b0;
        check_value("writeback count", dcache_pkg::word_t'(row_wb[i]),
                    dcache_pkg::word_t'(u_mem.wb_count - wb_start));
        check_value("refill count", dcache_pkg::word_t'(row_refill[i]),
                    dcache_pkg::word_t'(u_mem.refill_count - refill_start));
        // taken at the first edge and done two cycles later
        if (row_hit[i]) begin
            check_value("hit latency", 64'd3, dcache_pkg::word_t'(cycles));
        end
        if (row_wb[i] == 1) begin
            check_value("mem_addr_o", dcache_pkg::word_t'(row_wb_addr[i]),
                        dcache_pkg::word_t'(u_mem.last_wb_addr));
            check_value("mem_wdata_o", ref_read(row_wb_addr[i]), u_mem.last_wb_data);
        end
        if (row_op[i] == OP_READ) begin
            check_value("cpu_rdata_o", ref_read(row_addr[i]), rdata);
        end else begin
            check_value("cpu_rdata_o", 64'd0, rdata);
        end
        if (row_op[i] == OP_WRITE) begin
            ref_mem[line_of(row_addr[i])] = merge_bytes(ref_read(row_addr[i]),
                                                        row_wdata[i], row_strb[i]);
            written.push_back(line_of(row_addr[i]));
        end else if (row_op[i] == OP_FENCE) begin
            foreach (written[k]) begin
                check_value("memory line present", 64'd1,
                            dcache_pkg::word_t'(u_mem.store.exists(written[k])));
                check_value("memory word", ref_read(written[k]), u_mem.store[written[k]]);
            end
        end
    endtask

    initial begin
        rst_n_i     = 1'b0;
        cpu_read_i  = 1'b0;
        cpu_write_i = 1'b0;
        cpu_fence_i = 1'b0;
        cpu_addr_i  = '0;
        cpu_wdata_i = '0;
        cpu_strb_i  = '0;
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        @(posedge clk);
        check_value("cpu_done_o", 64'd0, dcache_pkg::word_t'(cpu_done_o));
        check_value("mem_op_o", dcache_pkg::word_t'(dcache_bus_pkg::MEM_NONE),
                    dcache_pkg::word_t'(mem_op_o));

        // op, addr, wdata, strb, hit, writebacks, refills, writeback addr
        add_row(OP_READ,  ADDR_D, 64'h0, 8'h00, 1'b0, 0, 1, 32'h0);
        add_row(OP_READ,  ADDR_D, 64'h0, 8'h00, 1'b1, 0, 0, 32'h0);
        add_row(OP_WRITE, ADDR_D, 64'h1122_3344_5566_7788, 8'h0f, 1'b1, 0, 0, 32'h0);
        add_row(OP_READ,  ADDR_D, 64'h0, 8'h00, 1'b1, 0, 0, 32'h0);
        // three dirty lines in set 5
        add_row(OP_WRITE, ADDR_A, 64'ha0a1_a2a3_a4a5_a6a7, 8'hff, 1'b0, 0, 1, 32'h0);
        add_row(OP_WRITE, ADDR_B, 64'hb0b1_b2b3_b4b5_b6b7, 8'hf0, 1'b0, 0, 1, 32'h0);
        add_row(OP_WRITE, ADDR_C, 64'hc0c1_c2c3_c4c5_c6c7, 8'h3c, 1'b0, 1, 1, ADDR_A);
        add_row(OP_READ,  ADDR_A, 64'h0, 8'h00, 1'b0, 1, 1, ADDR_B);
        add_row(OP_WRITE, ADDR_E, 64'he0e1_e2e3_e4e5_e6e7, 8'h81, 1'b0, 0, 1, 32'h0);
        add_row(OP_WRITE, ADDR_F, 64'hf0f1_f2f3_f4f5_f6f7, 8'hff, 1'b0, 0, 1, 32'h0);
        add_row(OP_WRITE, ADDR_D, 64'hdead_beef_0bad_cafe, 8'hf0, 1'b1, 0, 0, 32'h0);
        // D, C, E and F are dirty here
        add_row(OP_FENCE, 32'h0,  64'h0, 8'h00, 1'b0, 4, 0, 32'h0);
        add_row(OP_READ,  ADDR_D, 64'h0, 8'h00, 1'b0, 0, 1, 32'h0);

        foreach (row_op[i]) begin
            run_row(i);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

/* dcache_top.f */
+incdir+source
source/dcache_pkg.sv
source/dcache_bus_pkg.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tests/tb_dcache_mem.sv
tests/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# builds the data cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f dcache_top.f \
    --top-module tb_dcache \
    --Mdir obj_dir \
    -o tb_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

echo "simulation finished"
exit 0
